/* verilog/uart_line_pkg.sv */
// serial line definitions shared by the transmitter, the receiver and the FIFOs
// referenced by scoped name, never imported
`default_nettype none

package uart_line_pkg;

	// one data byte, on the wire or in a FIFO slot
	typedef logic [7:0] byte_t;

	// baud ticks per bit period
	localparam int OVERSAMPLE = 16;

	// serializer states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// deserializer states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_reg_pkg.sv */
// host register map of the uart and the bit layout of its status word
`default_nettype none

package uart_reg_pkg;

	// register address and baud divisor widths
	typedef logic [1:0] addr_t;
	typedef logic [15:0] divisor_t;

	// register map
	localparam addr_t ADDR_DATA = 2'd0;
	localparam addr_t ADDR_STATUS = 2'd1;
	localparam addr_t ADDR_DIV = 2'd2;

	// status word bit positions
	localparam int ST_TX_FULL = 0;
	localparam int ST_TX_EMPTY = 1;
	localparam int ST_RX_EMPTY = 2;
	localparam int ST_OVERRUN = 3;

endpackage

`default_nettype wire

/* verilog/uart_host_if.sv */
// link between the register block and the transmit and receive FIFOs
// the register block takes the host modport, the top wires fifo_side to the FIFOs
`timescale 1ns/1ps
`default_nettype none

interface uart_host_if;

	// transmit path, host pushes
	logic tx_wr;
	uart_line_pkg::byte_t tx_data;
	logic tx_full;
	logic tx_empty;

	// receive path, host pops
	logic rx_rd;
	uart_line_pkg::byte_t rx_data;
	logic rx_empty;
	logic rx_overflow;

	modport host (
		output tx_wr, tx_data, rx_rd,
		input tx_full, tx_empty, rx_data, rx_empty, rx_overflow
	);

	modport fifo_side (
		input tx_wr, tx_data, rx_rd,
		output tx_full, tx_empty, rx_data, rx_empty, rx_overflow
	);

endinterface

`default_nettype wire

/* verilog/fifo.sv */
// synchronous FIFO, head word visible on r_data without a read cycle
// drops writes while full and flags each dropped write on overflow
`timescale 1ns/1ps
`default_nettype none

module fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic wr,
	input logic [WIDTH-1:0] w_data,
	output logic empty,
	output logic full,
	output logic overflow,
	output logic [WIDTH-1:0] r_data
);

	localparam int PW = $clog2(DEPTH);

	logic [WIDTH-1:0] array_reg [DEPTH];
	logic [PW-1:0] w_ptr_reg, w_ptr_next, w_ptr_succ;
	logic [PW-1:0] r_ptr_reg, r_ptr_next, r_ptr_succ;
	logic full_next, empty_next;
	logic wr_en;

	// a read frees the slot when full, so both go through
	assign wr_en = wr & (~full | rd);

	// storage, no reset on payload
	always_ff @(posedge clk) begin
		if (wr_en) begin
			array_reg[w_ptr_reg] <= w_data;
		end
	end

	// first word fall through
	assign r_data = array_reg[r_ptr_reg];

	assign w_ptr_succ = w_ptr_reg + 1'b1;
	assign r_ptr_succ = r_ptr_reg + 1'b1;

	// ------------------------------------------------------------------
	// pointer and flag update
	// ------------------------------------------------------------------
	always_comb begin
		w_ptr_next = w_ptr_reg;
		r_ptr_next = r_ptr_reg;
		full_next = full;
		empty_next = empty;
		case ({wr, rd})
			2'b01: begin
				// read only, ignored when empty
				if (!empty) begin
					r_ptr_next = r_ptr_succ;
					full_next = 1'b0;
					empty_next = (r_ptr_succ == w_ptr_reg);
				end
			end
			2'b10: begin
				// write only, dropped when full
				if (!full) begin
					w_ptr_next = w_ptr_succ;
					empty_next = 1'b0;
					full_next = (w_ptr_succ == r_ptr_reg);
				end
			end
			2'b11: begin
				w_ptr_next = w_ptr_succ;
				if (!empty) begin
					// occupancy unchanged
					r_ptr_next = r_ptr_succ;
				end else begin
					empty_next = 1'b0;
					full_next = (w_ptr_succ == r_ptr_reg);
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			w_ptr_reg <= '0;
			r_ptr_reg <= '0;
			full <= 1'b0;
			empty <= 1'b1;
			overflow <= 1'b0;
		end else begin
			w_ptr_reg <= w_ptr_next;
			r_ptr_reg <= r_ptr_next;
			full <= full_next;
			empty <= empty_next;
			// one pulse per dropped write
			overflow <= wr & full & ~rd;
		end
	end

	// flags exclusive at every depth
	assert property (@(posedge clk) disable iff (rst) !(full && empty))
		else $error("fifo full and empty together");

endmodule

`default_nettype wire

/* verilog/uart_baud.sv */
// baud tick generator, one tick every divisor clocks
// tick rate is the 16x oversampling rate for both serial directions
`timescale 1ns/1ps
`default_nettype none

module uart_baud (
	input logic clk,
	input logic rst,
	input uart_reg_pkg::divisor_t divisor,
	output logic tick
);

	uart_reg_pkg::divisor_t cnt;
	uart_reg_pkg::divisor_t div_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			div_q <= '0;
			tick <= 1'b0;
		end else begin
			div_q <= divisor;
			tick <= 1'b0;
			// zero divisor stalls, a new divisor restarts the count
			if (divisor == '0 || divisor != div_q) begin
				cnt <= '0;
			end else if (cnt == divisor - 1'b1) begin
				cnt <= '0;
				tick <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
// transmit serializer, 8N1, pops the transmit FIFO one byte per frame
// bit timing comes from the baud tick, OVERSAMPLE ticks per bit
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic empty,
	input uart_line_pkg::byte_t r_data,
	output logic rd,
	output logic txd
);

	localparam int CW = $clog2(uart_line_pkg::OVERSAMPLE);

	uart_line_pkg::tx_state_t state;
	logic [CW-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	uart_line_pkg::byte_t shift;
	logic bit_done;

	// pop in the same cycle the frame starts
	assign rd = (state == uart_line_pkg::TX_IDLE) && tick && !empty;
	assign bit_done = tick && (tick_cnt == CW'(uart_line_pkg::OVERSAMPLE - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= uart_line_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			shift <= '0;
			txd <= 1'b1;
		end else begin
			if (tick && state != uart_line_pkg::TX_IDLE) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			case (state)
				uart_line_pkg::TX_IDLE: begin
					if (rd) begin
						shift <= r_data;
						tick_cnt <= '0;
						txd <= 1'b0;
						state <= uart_line_pkg::TX_START;
					end
				end
				uart_line_pkg::TX_START: begin
					if (bit_done) begin
						// lsb first
						txd <= shift[0];
						bit_cnt <= '0;
						state <= uart_line_pkg::TX_DATA;
					end
				end
				uart_line_pkg::TX_DATA: begin
					if (bit_done) begin
						shift <= shift >> 1;
						if (bit_cnt == 3'd7) begin
							txd <= 1'b1;
							state <= uart_line_pkg::TX_STOP;
						end else begin
							txd <= shift[1];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: begin
					// stop bit, line already high
					if (bit_done) begin
						state <= uart_line_pkg::TX_IDLE;
					end
				end
			endcase
		end
	end

	// idle line must be marking
	assert property (@(posedge clk) disable iff (rst)
		state == uart_line_pkg::TX_IDLE |-> txd)
		else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
// receive deserializer, 8N1, oversampled by the baud tick
// pushes each byte with a good stop bit into the receive FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic rxd,
	output logic wr,
	output uart_line_pkg::byte_t w_data
);

	localparam int CW = $clog2(uart_line_pkg::OVERSAMPLE);
	localparam logic [CW-1:0] HALF = CW'(uart_line_pkg::OVERSAMPLE / 2 - 1);
	localparam logic [CW-1:0] FULL = CW'(uart_line_pkg::OVERSAMPLE - 1);

	uart_line_pkg::rx_state_t state;
	logic rxd_s1, rxd_s2, rxd_q;
	logic [CW-1:0] tick_cnt;
	logic [2:0] bit_cnt;

	// two flop synchronizer plus one for edge detect
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_q <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_q <= rxd_s2;
		end
	end

	// ------------------------------------------------------------------
	// frame state machine
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= uart_line_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			w_data <= '0;
			wr <= 1'b0;
		end else begin
			wr <= 1'b0;
			if (tick && state != uart_line_pkg::RX_IDLE) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			case (state)
				uart_line_pkg::RX_IDLE: begin
					// falling edge only, a low line after a bad stop is ignored
					if (rxd_q && !rxd_s2) begin
						tick_cnt <= '0;
						state <= uart_line_pkg::RX_START;
					end
				end
				uart_line_pkg::RX_START: begin
					if (tick && tick_cnt == HALF) begin
						tick_cnt <= '0;
						bit_cnt <= '0;
						// glitch if the line went back high
						state <= rxd_s2 ? uart_line_pkg::RX_IDLE : uart_line_pkg::RX_DATA;
					end
				end
				uart_line_pkg::RX_DATA: begin
					if (tick && tick_cnt == FULL) begin
						// mid bit sample, lsb first
						w_data <= {rxd_s2, w_data[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= uart_line_pkg::RX_STOP;
						end
					end
				end
				default: begin
					if (tick && tick_cnt == FULL) begin
						// framing error drops the byte
						wr <= rxd_s2;
						state <= uart_line_pkg::RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_regs.sv */
// host register block, strobe decode, divisor, status and read data
// reads return one cycle after the strobe and hold until the next read
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
	input logic clk,
	input logic rst,
	input logic sel,
	input logic we,
	input uart_reg_pkg::addr_t addr,
	input logic [15:0] wdata,
	output logic [15:0] rdata,
	uart_host_if.host host,
	output uart_reg_pkg::divisor_t divisor
);

	logic rd_strobe;
	logic status_rd;
	logic overrun;
	logic [15:0] status;

	// ------------------------------------------------------------------
	// strobe decode
	// ------------------------------------------------------------------
	assign rd_strobe = sel & ~we;
	assign host.tx_wr = sel & we & (addr == uart_reg_pkg::ADDR_DATA);
	assign host.tx_data = wdata[7:0];
	// empty reads are ignored inside the FIFO
	assign host.rx_rd = rd_strobe & (addr == uart_reg_pkg::ADDR_DATA);
	assign status_rd = rd_strobe & (addr == uart_reg_pkg::ADDR_STATUS);

	always_comb begin
		status = '0;
		status[uart_reg_pkg::ST_TX_FULL] = host.tx_full;
		status[uart_reg_pkg::ST_TX_EMPTY] = host.tx_empty;
		status[uart_reg_pkg::ST_RX_EMPTY] = host.rx_empty;
		status[uart_reg_pkg::ST_OVERRUN] = overrun;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			divisor <= '0;
			overrun <= 1'b0;
			rdata <= '0;
		end else begin
			if (sel && we && addr == uart_reg_pkg::ADDR_DIV) begin
				divisor <= wdata;
			end
			// new overflow wins over the clear
			if (host.rx_overflow) begin
				overrun <= 1'b1;
			end else if (status_rd) begin
				overrun <= 1'b0;
			end
			if (rd_strobe) begin
				case (addr)
					uart_reg_pkg::ADDR_DATA: rdata <= {8'h00, host.rx_data};
					uart_reg_pkg::ADDR_STATUS: rdata <= status;
					uart_reg_pkg::ADDR_DIV: rdata <= divisor;
					default: rdata <= '0;
				endcase
			end
		end
	end

	// an overrun always leaves bytes in the receive FIFO
	assert property (@(posedge clk) disable iff (rst) host.rx_overflow |-> !host.rx_empty)
		else $error("rx overflow with receive FIFO empty");

endmodule

`default_nettype wire

/* verilog/uart_top.sv */
// uart top level, host strobe bus in, serial rxd and txd out
// DEPTH sizes both FIFOs
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic sel,
	input logic we,
	input uart_reg_pkg::addr_t addr,
	input logic [15:0] wdata,
	output logic [15:0] rdata,
	input logic rxd,
	output logic txd
);

	uart_host_if host_if ();

	uart_reg_pkg::divisor_t divisor;
	logic tick;
	logic tx_rd;
	uart_line_pkg::byte_t tx_r_data;
	logic rx_wr;
	uart_line_pkg::byte_t rx_w_data;

	// ------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------
	uart_regs u_regs (
		.clk(clk), .rst(rst), .sel(sel), .we(we), .addr(addr),
		.wdata(wdata), .rdata(rdata), .host(host_if.host), .divisor(divisor)
	);

	uart_baud u_baud (.clk(clk), .rst(rst), .divisor(divisor), .tick(tick));

	uart_rx u_rx (
		.clk(clk), .rst(rst), .tick(tick), .rxd(rxd), .wr(rx_wr), .w_data(rx_w_data)
	);

	// ------------------------------------------------------------------
	// FIFOs, host sides wired through the fifo_side signals
	// ------------------------------------------------------------------
	fifo #(.WIDTH(8), .DEPTH(DEPTH)) u_tx_fifo (
		.clk(clk), .rst(rst), .rd(tx_rd), .wr(host_if.tx_wr), .w_data(host_if.tx_data),
		.empty(host_if.tx_empty), .full(host_if.tx_full), .overflow(), .r_data(tx_r_data)
	);

	fifo #(.WIDTH(8), .DEPTH(DEPTH)) u_rx_fifo (
		.clk(clk), .rst(rst), .rd(host_if.rx_rd), .wr(rx_wr), .w_data(rx_w_data),
		.empty(host_if.rx_empty), .full(), .overflow(host_if.rx_overflow),
		.r_data(host_if.rx_data)
	);

	// output side
	uart_tx u_tx (
		.clk(clk), .rst(rst), .tick(tick), .empty(host_if.tx_empty),
		.r_data(tx_r_data), .rd(tx_rd), .txd(txd)
	);

endmodule

`default_nettype wire

/* verif/uart_tb.sv */
// self-checking testbench for the uart, host bus driven on the rising clock edge
// bytes and expected status words are loaded from verif/uart_patterns.hex
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	localparam int DIVISOR = 4;
	// 16x oversampling, one bit is 16 baud ticks
	localparam int BIT_CLKS = 16 * DIVISOR;
	localparam int POLL_LIMIT = 2000;
	localparam int EDGE_LIMIT = 500;

	logic clk;
	logic rst;
	logic sel;
	logic we;
	uart_reg_pkg::addr_t addr;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic txd;
	logic rxd;
	logic line_rxd;
	logic loopback;

	logic [15:0] patterns [0:21];
	int errors;
	int timeouts;
	bit aborted;

	// rxd follows txd in loopback, else the line driver
	assign rxd = loopback ? txd : line_rxd;

	uart_top #(.DEPTH(8)) u_dut (
		.clk(clk), .rst(rst), .sel(sel), .we(we), .addr(addr),
		.wdata(wdata), .rdata(rdata), .rxd(rxd), .txd(txd)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ------------------------------------------------------------------
	// host bus and line helpers
	// ------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		errors++;
		$display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
	endtask

	task automatic host_write(input uart_reg_pkg::addr_t a, input logic [15:0] d);
		@(posedge clk);
		sel <= 1'b1;
		we <= 1'b1;
		addr <= a;
		wdata <= d;
		@(posedge clk);
		sel <= 1'b0;
		we <= 1'b0;
	endtask

	// rdata valid from the cycle after the strobe, sampled mid-cycle
	task automatic host_read(input uart_reg_pkg::addr_t a, output logic [15:0] d);
		@(posedge clk);
		sel <= 1'b1;
		we <= 1'b0;
		addr <= a;
		@(posedge clk);
		sel <= 1'b0;
		@(negedge clk);
		d = rdata;
	endtask

	// poll status until rx empty drops
	task automatic wait_rx_ready(input string what);
		logic [15:0] s;
		int n;
		n = 0;
		host_read(uart_reg_pkg::ADDR_STATUS, s);
		while (s[uart_reg_pkg::ST_RX_EMPTY] && n < POLL_LIMIT) begin
			host_read(uart_reg_pkg::ADDR_STATUS, s);
			n++;
		end
		if (s[uart_reg_pkg::ST_RX_EMPTY]) begin
			timeouts++;
			aborted = 1'b1;
			$display("timeout: no byte reached the receive FIFO while %s", what);
		end
	endtask

	// one 8N1 frame on rxd, stop level chosen by the caller
	task automatic send_frame(input logic [7:0] data, input logic stop);
		int i;
		@(posedge clk);
		line_rxd <= 1'b0;
		repeat (BIT_CLKS) @(posedge clk);
		for (i = 0; i < 8; i++) begin
			line_rxd <= data[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
		line_rxd <= stop;
		repeat (BIT_CLKS) @(posedge clk);
		line_rxd <= 1'b1;
	endtask

	// ------------------------------------------------------------------
	// test steps
	// ------------------------------------------------------------------
	task automatic check_reset_state();
		logic [15:0] s;
		host_read(uart_reg_pkg::ADDR_STATUS, s);
		if (s !== patterns[18]) report_mismatch("status", s, patterns[18]);
		if (txd !== 1'b1) report_mismatch("txd", {15'd0, txd}, 16'h0001);
	endtask

	task automatic check_loopback();
		logic [15:0] d;
		int i;
		@(posedge clk);
		loopback <= 1'b1;
		host_write(uart_reg_pkg::ADDR_DIV, 16'(DIVISOR));
		for (i = 0; i < 6; i++) begin
			// random idle gap between writes
			repeat ($urandom % 5) @(posedge clk);
			host_write(uart_reg_pkg::ADDR_DATA, patterns[i]);
		end
		for (i = 0; i < 6; i++) begin
			wait_rx_ready("looping bytes back");
			if (aborted) return;
			host_read(uart_reg_pkg::ADDR_DATA, d);
			if (d !== {8'h00, patterns[i][7:0]})
				report_mismatch("rdata", d, {8'h00, patterns[i][7:0]});
		end
	endtask

	task automatic check_tx_line();
		logic [7:0] got;
		int n;
		int i;
		@(posedge clk);
		loopback <= 1'b0;
		host_write(uart_reg_pkg::ADDR_DATA, patterns[6]);
		// look for the start bit edge
		n = 0;
		@(negedge clk);
		while (txd && n < EDGE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (txd) begin
			timeouts++;
			aborted = 1'b1;
			$display("timeout: txd never went low after a data write");
			return;
		end
		// middle of the start bit, then one bit period per sample
		repeat (BIT_CLKS / 2) @(negedge clk);
		if (txd !== 1'b0) report_mismatch("txd start bit", {15'd0, txd}, 16'h0000);
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			got[i] = txd;
		end
		if (got !== patterns[6][7:0])
			report_mismatch("txd data", {8'h00, got}, {8'h00, patterns[6][7:0]});
		repeat (BIT_CLKS) @(negedge clk);
		if (txd !== 1'b1) report_mismatch("txd stop bit", {15'd0, txd}, 16'h0001);
	endtask

	task automatic check_overrun();
		logic [15:0] d;
		int i;
		// ten frames into an 8 deep FIFO, no reads
		for (i = 0; i < 10; i++) begin
			send_frame(patterns[7 + i][7:0], 1'b1);
		end
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[19]) report_mismatch("status", d, patterns[19]);
		// sticky bit gone after one status read
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[20]) report_mismatch("status", d, patterns[20]);
		for (i = 0; i < 8; i++) begin
			host_read(uart_reg_pkg::ADDR_DATA, d);
			if (d !== {8'h00, patterns[7 + i][7:0]})
				report_mismatch("rdata", d, {8'h00, patterns[7 + i][7:0]});
		end
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[18]) report_mismatch("status", d, patterns[18]);
	endtask

	task automatic check_empty_read();
		logic [15:0] d;
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[18]) report_mismatch("status", d, patterns[18]);
		// stale head word, value not defined by the bus
		host_read(uart_reg_pkg::ADDR_DATA, d);
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[18]) report_mismatch("status", d, patterns[18]);
		send_frame(patterns[17][7:0], 1'b1);
		wait_rx_ready("receiving after an empty read");
		if (aborted) return;
		host_read(uart_reg_pkg::ADDR_DATA, d);
		if (d !== {8'h00, patterns[17][7:0]})
			report_mismatch("rdata", d, {8'h00, patterns[17][7:0]});
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[18]) report_mismatch("status", d, patterns[18]);
	endtask

	task automatic check_bad_stop();
		logic [15:0] d;
		send_frame(patterns[21][7:0], 1'b0);
		// time for a wrongly accepted byte to land
		repeat (2 * BIT_CLKS) @(posedge clk);
		host_read(uart_reg_pkg::ADDR_STATUS, d);
		if (d !== patterns[18]) report_mismatch("status", d, patterns[18]);
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		void'($urandom(32'h2399_0298));
		$readmemh("verif/uart_patterns.hex", patterns);
		rst <= 1'b1;
		sel <= 1'b0;
		we <= 1'b0;
		addr <= '0;
		wdata <= '0;
		line_rxd <= 1'b1;
		loopback <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		check_reset_state();
		if (!aborted) check_loopback();
		if (!aborted) check_tx_line();
		if (!aborted) check_overrun();
		if (!aborted) check_empty_read();
		if (!aborted) check_bad_stop();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_top.f */
verilog/uart_line_pkg.sv
verilog/uart_reg_pkg.sv
verilog/uart_host_if.sv
verilog/fifo.sv
verilog/uart_baud.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
verif/uart_tb.sv

/* Makefile */
TOP := uart_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

obj_dir/V$(TOP): uart_top.f $(wildcard verilog/*.sv verif/*.sv verif/*.hex)
	verilator --binary --timing --assert -f uart_top.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f uart_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* verif/uart_patterns.hex */
// one hex word per entry, loaded in order into a 16-bit pattern memory
// groups: loopback bytes, txd decode byte, receive burst, byte after empty read, status words
// loopback bytes, entries 0-5
a5 3c 0f f0 81 7e
// byte decoded from txd, entry 6
d2
// receive burst of ten frames, entries 7-16
11 22 33 44 55 66 77 88 99 aa
// byte received after an empty data read, entry 17
5b
// status words: idle, overrun set, overrun cleared, entries 18-20
0006 000a 0002
// byte sent with a low stop bit, entry 21
c3
